// File: muldiv_pkg.sv
// Shared widths, types and RV32M opcode constants; imported by every RTL stage of the M slice
`default_nettype none

package muldiv_pkg;

    // Integer register width
    localparam int XLEN = 32;

    // Register index width, enough for 32 architectural registers
    localparam int REG_IDX_W = 5;

    // Instruction word width
    localparam int INSTR_W = 32;

    typedef logic [XLEN-1:0]      xlen_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;
    typedef logic [INSTR_W-1:0]   instr_t;

    // M-extension operations
    // The code order follows funct3, offset by one
    typedef enum logic [3:0] {
        M_OP_NONE   = 4'd0,
        M_OP_MUL    = 4'd1,
        M_OP_MULH   = 4'd2,
        M_OP_MULHSU = 4'd3,
        M_OP_MULHU  = 4'd4,
        M_OP_DIV    = 4'd5,
        M_OP_DIVU   = 4'd6,
        M_OP_REM    = 4'd7,
        M_OP_REMU   = 4'd8
    } m_op_e;

    // Major opcode of register-register instructions
    localparam logic [6:0] OPC_OP = 7'b0110011;

    // funct7 that selects the M-extension within OPC_OP
    localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

endpackage

`default_nettype wire

// File: m_issue.sv
// Issue stage: decodes an incoming instruction into an M operation and registers it for muldiv
`timescale 1ns/1ps
`default_nettype none

module m_issue import muldiv_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     flush_i,
    input  wire logic     instr_valid_i,
    input  wire instr_t   instr_i,
    input  wire xlen_t    rs1_data_i,
    input  wire xlen_t    rs2_data_i,
    output logic          issue_valid_o,
    output m_op_e         issue_op_o,
    output xlen_t         issue_op1_o,
    output xlen_t         issue_op2_o,
    output reg_idx_t      issue_rd_o
);

    m_op_e dec_op;
    logic  dec_is_m;

    assign dec_is_m = (instr_i[6:0] == OPC_OP) && (instr_i[31:25] == FUNCT7_MULDIV);

    // funct3 picks one of the eight M operations
    always_comb begin
        dec_op = M_OP_NONE;
        if (dec_is_m) begin
            case (instr_i[14:12])
                3'b000: dec_op = M_OP_MUL;
                3'b001: dec_op = M_OP_MULH;
                3'b010: dec_op = M_OP_MULHSU;
                3'b011: dec_op = M_OP_MULHU;
                3'b100: dec_op = M_OP_DIV;
                3'b101: dec_op = M_OP_DIVU;
                3'b110: dec_op = M_OP_REM;
                3'b111: dec_op = M_OP_REMU;
            endcase
        end
    end

    // Strobe is killed by flush, including an instruction arriving with it
    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            issue_valid_o <= 1'b0;
        end else begin
            issue_valid_o <= instr_valid_i && (dec_op != M_OP_NONE);
        end
    end

    always_ff @(posedge clk) begin
        if (instr_valid_i) begin
            issue_op_o  <= dec_op;
            issue_op1_o <= rs1_data_i;
            issue_op2_o <= rs2_data_i;
            issue_rd_o  <= instr_i[11:7];
        end
    end

    a_issue_op_known: assert property (@(posedge clk) disable iff (!rst_n)
        issue_valid_o |-> (issue_op_o != M_OP_NONE));

endmodule

`default_nettype wire

// File: muldiv.sv
// Single-step multiply/divide unit; computes an RV32M result and registers it with its destination
`timescale 1ns/1ps
`default_nettype none

module muldiv import muldiv_pkg::*; (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     flush_i,
    input  wire logic     issue_valid_i,
    input  wire m_op_e    issue_op_i,
    input  wire xlen_t    issue_op1_i,
    input  wire xlen_t    issue_op2_i,
    input  wire reg_idx_t issue_rd_i,
    output logic          res_valid_o,
    output xlen_t         res_data_o,
    output reg_idx_t      res_rd_o
);

    logic [2*XLEN-1:0] prod_uu;
    logic [2*XLEN-1:0] prod_ss;
    logic [2*XLEN-1:0] prod_su;

    xlen_t quot_s;
    xlen_t quot_u;
    xlen_t rem_s;
    xlen_t rem_u;
    xlen_t result;

    logic div_by_zero;
    logic div_overflow;

    // Products at double width
    // Low word of MUL is the same for every signedness
    always_comb begin
        prod_uu = {{XLEN{1'b0}}, issue_op1_i} * {{XLEN{1'b0}}, issue_op2_i};
        prod_ss = $signed({{XLEN{issue_op1_i[XLEN-1]}}, issue_op1_i})
                * $signed({{XLEN{issue_op2_i[XLEN-1]}}, issue_op2_i});
        // op1 signed, op2 unsigned
        prod_su = $signed({{XLEN{issue_op1_i[XLEN-1]}}, issue_op1_i})
                * $signed({{XLEN{1'b0}}, issue_op2_i});
    end

    assign div_by_zero  = (issue_op2_i == '0);
    assign div_overflow = (issue_op1_i == {1'b1, {(XLEN-1){1'b0}}})
                       && (issue_op2_i == '1);

    always_comb begin
        if (div_by_zero) begin
            quot_s = '1;
            quot_u = '1;
            rem_s  = issue_op1_i;
            rem_u  = issue_op1_i;
        end else begin
            quot_u = issue_op1_i / issue_op2_i;
            rem_u  = issue_op1_i % issue_op2_i;
            if (div_overflow) begin
                // Most negative / -1
                quot_s = issue_op1_i;
                rem_s  = '0;
            end else begin
                quot_s = $signed(issue_op1_i) / $signed(issue_op2_i);
                rem_s  = $signed(issue_op1_i) % $signed(issue_op2_i);
            end
        end
    end

    always_comb begin
        case (issue_op_i)
            M_OP_MUL:    result = prod_uu[XLEN-1:0];
            M_OP_MULH:   result = prod_ss[2*XLEN-1:XLEN];
            M_OP_MULHSU: result = prod_su[2*XLEN-1:XLEN];
            M_OP_MULHU:  result = prod_uu[2*XLEN-1:XLEN];
            M_OP_DIV:    result = quot_s;
            M_OP_DIVU:   result = quot_u;
            M_OP_REM:    result = rem_s;
            M_OP_REMU:   result = rem_u;
            default:     result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n || flush_i) begin
            res_valid_o <= 1'b0;
        end else begin
            res_valid_o <= issue_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (issue_valid_i) begin
            res_data_o <= result;
            res_rd_o   <= issue_rd_i;
        end
    end

    // Flush must kill the result stage at the following edge
    a_flush_kills_res: assert property (@(posedge clk) disable iff (!rst_n)
        flush_i |=> !res_valid_o);

endmodule

`default_nettype wire

// File: m_writeback.sv
// Writeback stage: holds the integer register file, commits muldiv results and flags each retire
`timescale 1ns/1ps
`default_nettype none

module m_writeback import muldiv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     res_valid_i,
    input  wire xlen_t    res_data_i,
    input  wire reg_idx_t res_rd_i,
    input  wire reg_idx_t rd_addr_i,
    output xlen_t         rd_data_o,
    output logic          wb_valid_o,
    output reg_idx_t      wb_rd_o,
    output xlen_t         wb_data_o
);

    xlen_t regs [NUM_REGS];
    logic  wr_en;
    logic  rd_hit;

    // x0 and indices beyond the file are dropped
    assign wr_en  = res_valid_i && (res_rd_i != '0) && (int'(res_rd_i) < NUM_REGS);
    assign rd_hit = (rd_addr_i != '0) && (int'(rd_addr_i) < NUM_REGS);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[res_rd_i] <= res_data_i;
        end
    end

    assign rd_data_o = rd_hit ? regs[rd_addr_i] : '0;

    // Retire strobe aligned with the register write
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_valid_o <= 1'b0;
        end else begin
            wb_valid_o <= wr_en;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            wb_rd_o   <= res_rd_i;
            wb_data_o <= res_data_i;
        end
    end

    a_no_x0_retire: assert property (@(posedge clk) disable iff (!rst_n)
        wb_valid_o |-> (wb_rd_o != '0));

endmodule

`default_nettype wire

// File: m_ext_top.sv
// Top of the RV32M execution slice; chains issue, muldiv and writeback with a fixed 3-cycle latency
`timescale 1ns/1ps
`default_nettype none

module m_ext_top import muldiv_pkg::*; #(
    parameter int NUM_REGS = 32
) (
    input  wire logic     clk,
    input  wire logic     rst_n,
    input  wire logic     flush_i,
    input  wire logic     instr_valid_i,
    input  wire instr_t   instr_i,
    input  wire xlen_t    rs1_data_i,
    input  wire xlen_t    rs2_data_i,
    input  wire reg_idx_t rd_addr_i,
    output xlen_t         rd_data_o,
    output logic          wb_valid_o,
    output reg_idx_t      wb_rd_o,
    output xlen_t         wb_data_o
);

    logic     issue_valid;
    m_op_e    issue_op;
    xlen_t    issue_op1;
    xlen_t    issue_op2;
    reg_idx_t issue_rd;

    logic     res_valid;
    xlen_t    res_data;
    reg_idx_t res_rd;

    m_issue i_issue (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .issue_valid_o (issue_valid),
        .issue_op_o    (issue_op),
        .issue_op1_o   (issue_op1),
        .issue_op2_o   (issue_op2),
        .issue_rd_o    (issue_rd)
    );

    muldiv i_muldiv (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .issue_valid_i (issue_valid),
        .issue_op_i    (issue_op),
        .issue_op1_i   (issue_op1),
        .issue_op2_i   (issue_op2),
        .issue_rd_i    (issue_rd),
        .res_valid_o   (res_valid),
        .res_data_o    (res_data),
        .res_rd_o      (res_rd)
    );

    m_writeback #(
        .NUM_REGS (NUM_REGS)
    ) i_writeback (
        .clk         (clk),
        .rst_n       (rst_n),
        .res_valid_i (res_valid),
        .res_data_i  (res_data),
        .res_rd_i    (res_rd),
        .rd_addr_i   (rd_addr_i),
        .rd_data_o   (rd_data_o),
        .wb_valid_o  (wb_valid_o),
        .wb_rd_o     (wb_rd_o),
        .wb_data_o   (wb_data_o)
    );

endmodule

`default_nettype wire

// File: tb_m_ext.sv
// Self-checking testbench for m_ext_top; run through flist.f, ends with $finish or $fatal
`timescale 1ns/1ps
`default_nettype none

module tb_m_ext import muldiv_pkg::*; ;

    localparam int NUM_REGS     = 32;
    localparam int RESET_CYCLES = 8;
    localparam int NUM_RANDOM   = 400;
    // Directed instructions plus the idle gaps between tests
    localparam int NUM_DIRECTED = 60;
    localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_RANDOM + NUM_DIRECTED
                                   + 3 * NUM_REGS + 100;

    logic     clk = 1'b0;
    logic     rst_n;
    logic     flush_i;
    logic     instr_valid_i;
    instr_t   instr_i;
    xlen_t    rs1_data_i;
    xlen_t    rs2_data_i;
    reg_idx_t rd_addr_i;
    xlen_t    rd_data_o;
    logic     wb_valid_o;
    reg_idx_t wb_rd_o;
    xlen_t    wb_data_o;

    reg_idx_t    exp_rd_q[$];
    xlen_t       exp_data_q[$];
    int          exp_cyc_q[$];
    xlen_t       shadow [NUM_REGS];
    int          cycle_cnt = 0;
    logic [31:0] rng_state = 32'd22;
    string       test_name = "reset";

    m_ext_top #(
        .NUM_REGS (NUM_REGS)
    ) i_dut (
        .clk           (clk),
        .rst_n         (rst_n),
        .flush_i       (flush_i),
        .instr_valid_i (instr_valid_i),
        .instr_i       (instr_i),
        .rs1_data_i    (rs1_data_i),
        .rs2_data_i    (rs2_data_i),
        .rd_addr_i     (rd_addr_i),
        .rd_data_o     (rd_data_o),
        .wb_valid_o    (wb_valid_o),
        .wb_rd_o       (wb_rd_o),
        .wb_data_o     (wb_data_o)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
    end

    function automatic logic [31:0] rand_word();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    // Expected M result for an op given as funct3
    function automatic xlen_t ref_m_op(input logic [2:0] f3, input xlen_t a, input xlen_t b);
        logic signed [63:0] sa;
        logic signed [63:0] sb;
        logic signed [63:0] q;
        logic [63:0]        ua;
        logic [63:0]        ub;
        logic [63:0]        p_ss;
        logic [63:0]        p_su;
        logic [63:0]        p_uu;
        logic               ovf;
        xlen_t              r;
        sa   = {{32{a[31]}}, a};
        sb   = {{32{b[31]}}, b};
        ua   = {32'h0, a};
        ub   = {32'h0, b};
        p_ss = sa * sb;
        p_su = sa * $signed(ub);
        p_uu = ua * ub;
        ovf  = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        r    = '0;
        case (f3)
            3'd0: r = p_ss[31:0];
            3'd1: r = p_ss[63:32];
            3'd2: r = p_su[63:32];
            3'd3: r = p_uu[63:32];
            3'd4: begin
                q = sa / sb;
                r = (b == '0) ? 32'hffff_ffff : (ovf ? a : q[31:0]);
            end
            3'd5: r = (b == '0) ? 32'hffff_ffff : a / b;
            3'd6: begin
                q = sa % sb;
                r = (b == '0) ? a : (ovf ? 32'h0 : q[31:0]);
            end
            default: r = (b == '0) ? a : a % b;
        endcase
        return r;
    endfunction

    task automatic abort_run();
        $display("Testbench failed");
        $fatal(1, "Run stopped on first error");
    endtask

    task automatic check_data(input string name, input xlen_t exp, input xlen_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_idx(input string name, input reg_idx_t exp, input reg_idx_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected x%0d actual x%0d", name, exp, act);
            abort_run();
        end
    endtask

    task automatic drive_instr(input instr_t instr, input xlen_t a, input xlen_t b);
        instr_valid_i = 1'b1;
        instr_i       = instr;
        rs1_data_i    = a;
        rs2_data_i    = b;
        @(posedge clk);
        #1;
        instr_valid_i = 1'b0;
    endtask

    task automatic issue_m(input logic [2:0] f3, input reg_idx_t rd, input xlen_t a,
                           input xlen_t b, input bit expect_ret);
        xlen_t exp_val;
        exp_val = ref_m_op(f3, a, b);
        if (expect_ret && rd != '0) begin
            exp_rd_q.push_back(rd);
            exp_data_q.push_back(exp_val);
            exp_cyc_q.push_back(cycle_cnt);
            shadow[rd] = exp_val;
        end
        drive_instr({FUNCT7_MULDIV, 5'd2, 5'd1, f3, rd, OPC_OP}, a, b);
    endtask

    // Latency is fixed, so a few idle cycles drain the pipe
    task automatic wait_idle();
        repeat (5) @(posedge clk);
        #1;
        if (exp_rd_q.size() != 0) begin
            $display("Retire for x%0d never arrived in %s", exp_rd_q[0], test_name);
            abort_run();
        end
    endtask

    task automatic read_all_regs();
        for (int i = 0; i < NUM_REGS; i++) begin
            rd_addr_i = reg_idx_t'(i);
            @(negedge clk);
            check_data($sformatf("%s x%0d", test_name, i), shadow[i], rd_data_o);
            @(posedge clk);
            #1;
        end
    endtask

    always @(negedge clk) begin : compare_retire
        int exp_cyc;
        if (rst_n && wb_valid_o) begin
            if (exp_rd_q.size() == 0) begin
                $display("Retire strobe for x%0d with no instruction pending in %s",
                         wb_rd_o, test_name);
                abort_run();
            end else begin
                exp_cyc = exp_cyc_q.pop_front();
                if (cycle_cnt != exp_cyc + 3) begin
                    $display("Retire in %s came %0d cycles after the strobe instead of 3",
                             test_name, cycle_cnt - exp_cyc);
                    abort_run();
                end else begin
                    check_idx(test_name, exp_rd_q.pop_front(), wb_rd_o);
                    check_data(test_name, exp_data_q.pop_front(), wb_data_o);
                end
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired after %0d cycles in %s", WATCHDOG_CYCLES, test_name);
        abort_run();
    end

    initial begin
        logic [31:0] r;
        xlen_t       a;
        xlen_t       b;
        rst_n         = 1'b0;
        flush_i       = 1'b0;
        instr_valid_i = 1'b0;
        instr_i       = '0;
        rs1_data_i    = '0;
        rs2_data_i    = '0;
        rd_addr_i     = '0;
        for (int i = 0; i < NUM_REGS; i++) begin
            shadow[i] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_name = "reset_readback";
        read_all_regs();

        test_name = "corners";
        issue_m(3'd4, 5'd1, 32'd7, 32'd0, 1'b1);
        issue_m(3'd5, 5'd2, 32'd7, 32'd0, 1'b1);
        issue_m(3'd6, 5'd3, -32'sd7, 32'd0, 1'b1);
        issue_m(3'd7, 5'd4, 32'd7, 32'd0, 1'b1);
        issue_m(3'd4, 5'd5, 32'h8000_0000, 32'hffff_ffff, 1'b1);
        issue_m(3'd6, 5'd6, 32'h8000_0000, 32'hffff_ffff, 1'b1);
        issue_m(3'd1, 5'd7, -32'sd3, 32'd5, 1'b1);
        issue_m(3'd1, 5'd8, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
        issue_m(3'd2, 5'd9, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
        issue_m(3'd3, 5'd10, 32'hffff_ffff, 32'hffff_ffff, 1'b1);
        issue_m(3'd2, 5'd11, 32'h8000_0000, 32'd2, 1'b1);
        issue_m(3'd0, 5'd12, -32'sd3, 32'd7, 1'b1);
        issue_m(3'd4, 5'd13, -32'sd7, 32'd2, 1'b1);
        issue_m(3'd6, 5'd14, -32'sd7, 32'd2, 1'b1);
        wait_idle();

        test_name = "non_m";
        // OP-IMM opcode, then ADD and SUB funct7
        drive_instr({FUNCT7_MULDIV, 5'd2, 5'd1, 3'd0, 5'd15, 7'b0010011}, 32'd3, 32'd4);
        drive_instr({7'b0000000, 5'd2, 5'd1, 3'd0, 5'd16, OPC_OP}, 32'd3, 32'd4);
        drive_instr({7'b0100000, 5'd2, 5'd1, 3'd4, 5'd17, OPC_OP}, 32'd3, 32'd4);
        wait_idle();

        test_name = "x0_write";
        issue_m(3'd0, 5'd0, 32'd9, 32'd9, 1'b1);
        wait_idle();
        rd_addr_i = '0;
        @(negedge clk);
        check_data(test_name, 32'h0, rd_data_o);
        @(posedge clk);
        #1;

        test_name = "random";
        for (int n = 0; n < NUM_RANDOM; n++) begin
            r = rand_word();
            a = rand_word();
            b = rand_word();
            if (r[10:8] == 3'd0) begin
                b = '0;
            end else if (r[10:8] == 3'd1) begin
                a = 32'h8000_0000;
                b = '1;
            end
            issue_m(r[2:0], r[7:3], a, b, 1'b1);
        end
        wait_idle();
        test_name = "random_readback";
        read_all_regs();

        test_name = "flush";
        issue_m(3'd0, 5'd20, 32'd6, 32'd7, 1'b1);
        // x21 sits in muldiv at the flush edge and still retires
        issue_m(3'd4, 5'd21, 32'd100, 32'd9, 1'b1);
        issue_m(3'd6, 5'd22, 32'd100, 32'd9, 1'b0);
        // Strobe arriving together with flush is dropped as well
        flush_i = 1'b1;
        issue_m(3'd0, 5'd23, 32'd5, 32'd5, 1'b0);
        flush_i = 1'b0;
        wait_idle();
        test_name = "flush_readback";
        read_all_regs();

        if (exp_rd_q.size() != 0) begin
            $display("Retires still pending at the end of the run");
            abort_run();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: flist.f
muldiv_pkg.sv
m_issue.sv
muldiv.sv
m_writeback.sv
m_ext_top.sv
tb_m_ext.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator and runs it; exit status is the simulation result

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module tb_m_ext -o sim_m_ext
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/sim_m_ext
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation failed with status $status"
    exit $status
fi

echo "Simulation finished without errors"
exit 0
